/* verif/ps2_vectors.txt */
# columns: operation, byte (hex), translate flag, expected code (hex),
# expected released flag, expected no-ack error flag
key      1c 1 1c 0 0
key      f0 1 00 0 0
key      1c 1 1c 1 0
key      32 1 32 0 0
key      f0 0 f0 0 0
key      32 0 32 0 0
tx       ed 0 ed 0 0
tx       00 0 00 0 0
tx_noack f4 0 f4 0 1
tx       ff 0 ff 0 0
glitch   5a 1 5a 0 0
key      f0 1 00 0 0
key      5a 1 5a 1 0
key      29 1 29 0 0

/* list.f */
design/ps2_frame_pkg.sv
design/ps2_ctrl_pkg.sv
design/ps2_line_ctrl.sv
design/ps2_timers.sv
design/ps2_frame_shifter.sv
design/ps2_rx_output.sv
design/ps2_keyboard.sv
verif/ps2_clock_gen.sv
verif/ps2_kbd_model.sv
verif/tb_ps2_keyboard.sv

/* run.sh */
#!/bin/bash
# Build the PS/2 keyboard testbench with Verilator and run it.
# The run passes only if the simulation prints the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_ps2_keyboard -o sim_ps2 \
  && ./obj_dir/sim_ps2 | tee /dev/stderr | grep -qx "TEST PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verif/tb_ps2_keyboard.sv */
//----------------------------------------------------------
// Testbench for the PS/2 keyboard host interface. Reads one
// test per line from the vector file, plays it through the
// keyboard model and the host ports, checks the results and
// prints one line per test and a closing count line
//----------------------------------------------------------

`timescale 1ns/10ps

module tb_ps2_keyboard;

  import ps2_frame_pkg::*;
  import ps2_ctrl_pkg::*;

  localparam int inhibit_ticks_c  = 20;
  localparam int prescale_div_c   = 4;
  localparam int half_period_c    = 40;
  localparam int inhibit_cycles_c = inhibit_ticks_c * prescale_div_c;

  logic       clk;
  logic       reset;
  logic       kbd_clk;
  logic       kbd_data;
  logic       ps2_clk_line;
  logic       ps2_data_line;
  logic       ps2_clk_drive_low;
  logic       ps2_data_drive_low;
  logic       rx_read;
  scan_code_t tx_data;
  logic       tx_write;
  logic       translate;
  scan_code_t rx_scan_code;
  logic       rx_released;
  logic       rx_data_ready;
  logic       tx_write_ack;
  logic       tx_error_no_ack;

  // vectors with one entry per test
  string      op_q[$];
  scan_code_t code_q[$];
  logic       translate_q[$];
  scan_code_t expect_code_q[$];
  logic       expect_rel_q[$];
  logic       expect_err_q[$];

  int   test_errors  = 0;
  int   tests_failed = 0;
  int   ready_events = 0;
  int   error_cycles = 0;
  int   cycle_count  = 0;
  int   cycle_limit  = 0;
  logic ready_q      = 1'b0;
  logic vectors_ok;

  ps2_clock_gen i_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  ps2_kbd_model #(
    .half_period_p (half_period_c)
  ) i_kbd (
    .clk        (clk),
    .ps2_clk_i  (ps2_clk_line),
    .ps2_data_i (ps2_data_line),
    .kbd_clk_o  (kbd_clk),
    .kbd_data_o (kbd_data)
  );

  // on the open drain lines either side can pull a line low
  assign ps2_clk_line  = kbd_clk & ~ps2_clk_drive_low;
  assign ps2_data_line = kbd_data & ~ps2_data_drive_low;

  ps2_keyboard #(
    .inhibit_ticks_p (inhibit_ticks_c),
    .prescale_div_p  (prescale_div_c)
  ) i_dut (
    .clk                  (clk),
    .reset                (reset),
    .ps2_clk_i            (ps2_clk_line),
    .ps2_data_i           (ps2_data_line),
    .rx_read_i            (rx_read),
    .tx_data_i            (tx_data),
    .tx_write_i           (tx_write),
    .translate_i          (translate),
    .ps2_clk_drive_low_o  (ps2_clk_drive_low),
    .ps2_data_drive_low_o (ps2_data_drive_low),
    .rx_scan_code_o       (rx_scan_code),
    .rx_released_o        (rx_released),
    .rx_data_ready_o      (rx_data_ready),
    .tx_write_ack_o       (tx_write_ack),
    .tx_error_no_ack_o    (tx_error_no_ack)
  );

  //----------------------------------------------------------
  // monitors and run limit
  //----------------------------------------------------------

  // counts ready rising edges and cycles spent in the no-ack error
  always @(negedge clk)
  begin
    ready_q <= rx_data_ready;
    if (rx_data_ready && !ready_q)
      ready_events <= ready_events + 1;
    if (tx_error_no_ack)
      error_cycles <= error_cycles + 1;
  end

  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  initial
  begin
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit)
      @(posedge clk);
    $display("run stopped after %0d cycles without finishing the tests", cycle_count);
    $display("TEST FAILED");
    $finish;
  end

  //----------------------------------------------------------
  // helpers
  //----------------------------------------------------------

  task automatic read_vectors(output logic ok);
    int    fd;
    int    n;
    string line;
    string op;
    int    code;
    int    tr;
    int    exp_code;
    int    exp_rel;
    int    exp_err;
    ok = 1'b0;
    fd = $fopen("verif/ps2_vectors.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        // lines starting with # describe the columns
        if (n > 1 && line.substr(0, 0) != "#" &&
            $sscanf(line, "%s %h %d %h %d %d", op, code, tr, exp_code, exp_rel, exp_err) == 6)
        begin
          op_q.push_back(op);
          code_q.push_back(8'(code));
          translate_q.push_back(tr != 0);
          expect_code_q.push_back(8'(exp_code));
          expect_rel_q.push_back(exp_rel != 0);
          expect_err_q.push_back(exp_err != 0);
        end
      end
      $fclose(fd);
      ok = (op_q.size() > 0);
    end
  endtask

  task automatic wait_clocks(input int count);
    repeat (count)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    assert (actual === expected)
    else
    begin
      $display("ERROR %s expected %h got %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic expect_flag(input string name, input logic expected, input logic actual);
    assert (actual === expected)
    else
    begin
      $display("ERROR %s expected %h got %h", name, expected, actual);
      test_errors++;
    end
  endtask

  // checks the delivered code, does the read and sees ready drop
  task automatic check_delivery(input scan_code_t exp_code, input logic exp_rel,
                                input int events_before);
    logic found;
    found = 1'b0;
    for (int n = 0; n < 200 && !found; n++)
    begin
      @(negedge clk);
      found = rx_data_ready;
    end
    assert (found)
    else
    begin
      $display("rx_data_ready_o never rose after the frame");
      test_errors++;
    end
    if (found)
    begin
      check_byte("rx_scan_code_o", exp_code, rx_scan_code);
      expect_flag("rx_released_o", exp_rel, rx_released);
      @(posedge clk);
      #1;
      rx_read = 1'b1;
      @(posedge clk);
      #1;
      rx_read = 1'b0;
      @(negedge clk);
      expect_flag("rx_data_ready_o", 1'b0, rx_data_ready);
      assert (ready_events == events_before + 1)
      else
      begin
        $display("expected one ready event but saw %0d", ready_events - events_before);
        test_errors++;
      end
    end
    wait_clocks(1);
  endtask

  // a release prefix with translation on must give no output at all
  task automatic play_key(input scan_code_t code, input logic tr,
                          input scan_code_t exp_code, input logic exp_rel);
    int events_before;
    events_before = ready_events;
    i_kbd.send_frame(code, 11);
    if (tr && code == release_code_c)
    begin
      wait_clocks(20);
      assert (ready_events == events_before && !rx_data_ready)
      else
      begin
        $display("the release prefix was delivered instead of absorbed");
        test_errors++;
      end
    end
    else
      check_delivery(exp_code, exp_rel, events_before);
  endtask

  task automatic write_command(input scan_code_t code, output logic ack_seen);
    tx_data  = code;
    tx_write = 1'b1;
    ack_seen = 1'b0;
    for (int n = 0; n < 50 && !ack_seen; n++)
    begin
      @(negedge clk);
      ack_seen = tx_write_ack;
    end
    // the edge after the ack loads the command frame
    @(posedge clk);
    #1;
    tx_write = 1'b0;
  endtask

  task automatic issue_command(input scan_code_t code, input logic give_ack,
                               input scan_code_t exp_code, input logic exp_err);
    scan_code_t got;
    logic       parity;
    logic       start_bit;
    int         low_cycles;
    logic       ack_seen;
    logic       idle;
    int         err_before;
    err_before = error_cycles;
    fork
      i_kbd.receive_command(give_ack, got, parity, start_bit, low_cycles);
      write_command(code, ack_seen);
    join
    idle = 1'b0;
    for (int n = 0; n < 500 && !idle; n++)
    begin
      @(negedge clk);
      idle = (i_dut.i_line_ctrl.line_state_o == rx_clk_high);
    end
    assert (ack_seen)
    else
    begin
      $display("tx_write_ack_o never rose for the command");
      test_errors++;
    end
    assert (idle)
    else
    begin
      $display("the line FSM did not return to receive idle");
      test_errors++;
    end
    assert (low_cycles >= inhibit_cycles_c)
    else
    begin
      $display("clock held low for %0d cycles, shorter than %0d", low_cycles, inhibit_cycles_c);
      test_errors++;
    end
    expect_flag("ps2_data start bit", 1'b0, start_bit);
    check_byte("ps2_data command byte", exp_code, got);
    // with odd parity the byte and its parity bit hold an odd number of ones
    expect_flag("ps2_data parity bit", 1'b1, ^{code, parity});
    expect_flag("tx_error_no_ack_o seen", exp_err, error_cycles != err_before);
    expect_flag("tx_error_no_ack_o", 1'b0, tx_error_no_ack);
    wait_clocks(1);
  endtask

  // a partial frame, then an idle clock past the watchdog period
  task automatic glitch_recovery(input scan_code_t code, input scan_code_t exp_code,
                                 input logic exp_rel);
    int events_before;
    events_before = ready_events;
    i_kbd.send_frame(~code, 4);
    wait_clocks(2 * inhibit_cycles_c);
    i_kbd.send_frame(code, 11);
    check_delivery(exp_code, exp_rel, events_before);
  endtask

  //----------------------------------------------------------
  // main sequence
  //----------------------------------------------------------

  initial
  begin
    rx_read   = 1'b0;
    tx_data   = '0;
    tx_write  = 1'b0;
    translate = 1'b0;
    void'($urandom(32'hd346));
    read_vectors(vectors_ok);
    if (!vectors_ok)
    begin
      $display("could not read any test from the vector file");
      $display("TEST FAILED");
      $finish;
    end
    else
    begin
      cycle_limit = 4000 * op_q.size();
      wait (reset == 1'b0);
      @(negedge clk);
      expect_flag("ps2_clk_drive_low_o", 1'b0, ps2_clk_drive_low);
      expect_flag("ps2_data_drive_low_o", 1'b0, ps2_data_drive_low);
      expect_flag("rx_data_ready_o", 1'b0, rx_data_ready);
      expect_flag("tx_write_ack_o", 1'b0, tx_write_ack);
      expect_flag("tx_error_no_ack_o", 1'b0, tx_error_no_ack);
      check_byte("rx_scan_code_o", 8'h00, rx_scan_code);
      $display("test 0 reset: %s", (test_errors == 0) ? "ok" : "mismatch");
      if (test_errors != 0)
        tests_failed++;
      wait_clocks(5);
      foreach (op_q[i])
      begin
        test_errors = 0;
        translate   = translate_q[i];
        if (op_q[i] == "key")
          play_key(code_q[i], translate_q[i], expect_code_q[i], expect_rel_q[i]);
        else if (op_q[i] == "tx" || op_q[i] == "tx_noack")
          issue_command(code_q[i], op_q[i] == "tx", expect_code_q[i], expect_err_q[i]);
        else if (op_q[i] == "glitch")
          glitch_recovery(code_q[i], expect_code_q[i], expect_rel_q[i]);
        else
        begin
          $display("unknown operation %s in the vector file", op_q[i]);
          test_errors++;
        end
        $display("test %0d %s %h: %s", i + 1, op_q[i], code_q[i],
                 (test_errors == 0) ? "ok" : "mismatch");
        if (test_errors != 0)
          tests_failed++;
        // idle gap between tests
        wait_clocks(20 + int'($urandom % 40));
      end
      $display("tests run %0d, failed %0d", op_q.size() + 1, tests_failed);
      if (tests_failed == 0)
        $display("TEST PASSED");
      else
        $display("TEST FAILED");
      $finish;
    end
  end

endmodule

/* verif/ps2_kbd_model.sv */
//----------------------------------------------------------
// Behavioral PS/2 keyboard for the testbench. Its tasks are
// called from the testbench top: one sends a device-to-host
// frame, the other clocks in a host command and answers
// with or without the acknowledge bit. Outputs are the
// keyboard's own open-drain drives, 1 meaning released
//----------------------------------------------------------

`timescale 1ns/10ps

module ps2_kbd_model #(
  parameter int half_period_p = 40
) (
  input  logic clk,
  input  logic ps2_clk_i,
  input  logic ps2_data_i,
  output logic kbd_clk_o,
  output logic kbd_data_o
);

  // both lines start released so the pullups hold them high
  initial
  begin
    kbd_clk_o  = 1'b1;
    kbd_data_o = 1'b1;
  end

  // every wait ends 1 ns after a rising edge, where lines change
  task automatic wait_cycles(input int count);
    repeat (count)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  //----------------------------------------------------------
  // device to host
  //----------------------------------------------------------

  // data changes in the middle of the high phase, the host
  // samples it on the falling clock; bit_total below 11 leaves
  // a partial frame behind
  task automatic send_frame(input logic [7:0] code, input int bit_total);
    logic [10:0] frame;
    frame = {1'b1, ~^code, code, 1'b0};
    for (int i = 0; i < bit_total; i++)
    begin
      kbd_data_o = frame[4'(i)];
      wait_cycles(half_period_p / 2);
      kbd_clk_o = 1'b0;
      wait_cycles(half_period_p);
      kbd_clk_o = 1'b1;
      wait_cycles(half_period_p / 2);
    end
    kbd_data_o = 1'b1;
  endtask

  //----------------------------------------------------------
  // host to device
  //----------------------------------------------------------

  // measures how long the host inhibits the clock, then gives
  // eleven clock pulses and samples the data line at the end of
  // each high phase, so bit 0 is the start bit and bit 10 is
  // the released stop bit
  task automatic receive_command(
    input  logic       give_ack,
    output logic [7:0] code,
    output logic       parity,
    output logic       start_bit,
    output int         low_cycles
  );
    logic [10:0] bits;
    low_cycles = 0;
    while (ps2_clk_i)
      wait_cycles(1);
    while (!ps2_clk_i)
    begin
      low_cycles++;
      wait_cycles(1);
    end
    wait_cycles(half_period_p / 2);
    for (int i = 0; i < 11; i++)
    begin
      bits[4'(i)] = ps2_data_i;
      // the ack is data held low across the last clock pulse
      if (i == 10 && give_ack)
      begin
        kbd_data_o = 1'b0;
        wait_cycles(half_period_p / 4);
      end
      kbd_clk_o = 1'b0;
      wait_cycles(half_period_p);
      kbd_clk_o = 1'b1;
      wait_cycles(half_period_p);
    end
    kbd_data_o = 1'b1;
    wait_cycles(half_period_p / 2);
    start_bit = bits[0];
    code      = bits[8:1];
    parity    = bits[9];
  endtask

endmodule

/* verif/ps2_clock_gen.sv */
//----------------------------------------------------------
// Clock and reset source for the PS/2 testbench. Makes a
// free running clock and holds reset high for the first
// few rising edges
//----------------------------------------------------------

`timescale 1ns/10ps

module ps2_clock_gen #(
  parameter int period_p       = 8,
  parameter int reset_cycles_p = 2
) (
  output logic clk_o,
  output logic reset_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // reset drops just after an edge, like every other driven input
  initial
  begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

/* design/ps2_keyboard.sv */
//----------------------------------------------------------
// PS/2 keyboard host interface, top level. Connects the line
// FSM to the timers, the frame shifter and the receive
// output stage. The PS/2 lines are open drain: a high drive
// output pulls the line low, otherwise the pullup holds it
//----------------------------------------------------------

`timescale 1ns/10ps

module ps2_keyboard #(
  parameter int unsigned inhibit_ticks_p = 2950,
  parameter int unsigned prescale_div_p  = 186
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ps2_clk_i,
  input  logic                      ps2_data_i,
  input  logic                      rx_read_i,
  input  ps2_frame_pkg::scan_code_t tx_data_i,
  input  logic                      tx_write_i,
  input  logic                      translate_i,
  output logic                      ps2_clk_drive_low_o,
  output logic                      ps2_data_drive_low_o,
  output ps2_frame_pkg::scan_code_t rx_scan_code_o,
  output logic                      rx_released_o,
  output logic                      rx_data_ready_o,
  output logic                      tx_write_ack_o,
  output logic                      tx_error_no_ack_o
);

  import ps2_frame_pkg::*;
  import ps2_ctrl_pkg::*;

  line_state_t line_state;
  logic        ps2_data_sync;
  logic        ps2_clk_sync;
  logic        inhibit_en;
  logic        debounce_en;
  logic        inhibit_done;
  logic        debounce_done;
  logic        tx_bit;
  logic        tx_shift_done;
  logic        rx_frame_done;
  scan_code_t  rx_byte;

  ps2_line_ctrl i_line_ctrl (
    .clk                  (clk),
    .reset                (reset),
    .ps2_clk_i            (ps2_clk_i),
    .ps2_data_i           (ps2_data_i),
    .tx_write_i           (tx_write_i),
    .tx_bit_i             (tx_bit),
    .tx_shift_done_i      (tx_shift_done),
    .inhibit_done_i       (inhibit_done),
    .debounce_done_i      (debounce_done),
    .line_state_o         (line_state),
    .ps2_data_sync_o      (ps2_data_sync),
    .ps2_clk_sync_o       (ps2_clk_sync),
    .inhibit_en_o         (inhibit_en),
    .debounce_en_o        (debounce_en),
    .ps2_clk_drive_low_o  (ps2_clk_drive_low_o),
    .ps2_data_drive_low_o (ps2_data_drive_low_o),
    .tx_write_ack_o       (tx_write_ack_o),
    .tx_error_no_ack_o    (tx_error_no_ack_o)
  );

  ps2_timers #(
    .inhibit_ticks_p (inhibit_ticks_p),
    .prescale_div_p  (prescale_div_p)
  ) i_timers (
    .clk             (clk),
    .reset           (reset),
    .inhibit_en_i    (inhibit_en),
    .debounce_en_i   (debounce_en),
    .inhibit_done_o  (inhibit_done),
    .debounce_done_o (debounce_done)
  );

  // the write ack doubles as the load strobe for the command frame
  ps2_frame_shifter i_frame_shifter (
    .clk             (clk),
    .reset           (reset),
    .line_state_i    (line_state),
    .ps2_data_sync_i (ps2_data_sync),
    .ps2_clk_sync_i  (ps2_clk_sync),
    .inhibit_done_i  (inhibit_done),
    .tx_load_i       (tx_write_ack_o),
    .tx_data_i       (tx_data_i),
    .tx_bit_o        (tx_bit),
    .tx_shift_done_o (tx_shift_done),
    .rx_frame_done_o (rx_frame_done),
    .rx_byte_o       (rx_byte)
  );

  ps2_rx_output i_rx_output (
    .clk             (clk),
    .reset           (reset),
    .rx_frame_done_i (rx_frame_done),
    .rx_byte_i       (rx_byte),
    .translate_i     (translate_i),
    .rx_read_i       (rx_read_i),
    .rx_scan_code_o  (rx_scan_code_o),
    .rx_released_o   (rx_released_o),
    .rx_data_ready_o (rx_data_ready_o)
  );

endmodule

/* design/ps2_rx_output.sv */
//----------------------------------------------------------
// Receive output stage. Absorbs the release prefix when
// translation is on and flags the following code as a
// release, registers the scan code and holds it behind the
// ready/read handshake
//----------------------------------------------------------

`timescale 1ns/10ps

module ps2_rx_output (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      rx_frame_done_i,
  input  ps2_frame_pkg::scan_code_t rx_byte_i,
  input  logic                      translate_i,
  input  logic                      rx_read_i,
  output ps2_frame_pkg::scan_code_t rx_scan_code_o,
  output logic                      rx_released_o,
  output logic                      rx_data_ready_o
);

  import ps2_frame_pkg::*;

  logic release_frame;
  logic out_strobe;
  logic hold_released;

  // a release prefix produces no output of its own
  assign release_frame = rx_frame_done_i && translate_i && (rx_byte_i == release_code_c);
  assign out_strobe    = rx_frame_done_i && !release_frame;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hold_released   <= 1'b0;
      rx_scan_code_o  <= '0;
      rx_released_o   <= 1'b0;
      rx_data_ready_o <= 1'b0;
    end
    else
    begin
      if (out_strobe)
      begin
        rx_scan_code_o <= rx_byte_i;
        rx_released_o  <= hold_released;
        hold_released  <= 1'b0;
      end
      else if (release_frame)
        hold_released <= 1'b1;
      // ready stays up through an overwrite until the host reads
      if (!rx_data_ready_o)
        rx_data_ready_o <= out_strobe;
      else if (rx_read_i)
        rx_data_ready_o <= 1'b0;
    end
  end

endmodule

/* design/ps2_frame_shifter.sv */
//----------------------------------------------------------
// Frame shift register and bit counter. One register serves
// both directions: it loads a framed command byte for
// transmit and collects the incoming frame on receive. The
// counter marks the end of either frame and is cleared by
// the watchdog after a long idle clock
//----------------------------------------------------------

`timescale 1ns/10ps

module ps2_frame_shifter (
  input  logic                      clk,
  input  logic                      reset,
  input  ps2_ctrl_pkg::line_state_t line_state_i,
  input  logic                      ps2_data_sync_i,
  input  logic                      ps2_clk_sync_i,
  input  logic                      inhibit_done_i,
  input  logic                      tx_load_i,
  input  ps2_frame_pkg::scan_code_t tx_data_i,
  output logic                      tx_bit_o,
  output logic                      tx_shift_done_o,
  output logic                      rx_frame_done_o,
  output ps2_frame_pkg::scan_code_t rx_byte_o
);

  import ps2_frame_pkg::*;
  import ps2_ctrl_pkg::*;

  logic [frame_bits_c-1:0] frame_q;
  bit_count_t              bit_count;
  logic                    tx_parity;
  logic                    shift_en;
  logic                    watchdog_clear;

  // odd parity over the command byte
  assign tx_parity = ~^tx_data_i;

  // data moves on the receive fall marker and the transmit rise marker
  assign shift_en = (line_state_i == rx_fall_mark) || (line_state_i == tx_rise_mark);

  // an idle clock for the whole watchdog period drops a partial frame
  assign watchdog_clear = inhibit_done_i && (line_state_i == rx_clk_high) && ps2_clk_sync_i;

  always_ff @(posedge clk)
  begin
    if (tx_load_i)
      frame_q <= {1'b1, tx_parity, tx_data_i, 1'b0};
    else if (shift_en)
      frame_q <= {ps2_data_sync_i, frame_q[frame_bits_c-1:1]};
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bit_count <= '0;
    else if (rx_frame_done_o || (line_state_i == tx_wait_ack) || watchdog_clear)
      bit_count <= '0;
    else if (shift_en)
      bit_count <= bit_count + 1'b1;
  end

  // the register bottom bit is the next bit on the data line
  assign tx_bit_o        = frame_q[0];
  assign tx_shift_done_o = (bit_count == bit_count_t'(tx_last_bit_c));
  assign rx_frame_done_o = (bit_count == bit_count_t'(frame_bits_c));
  assign rx_byte_o       = frame_q[8:1];

endmodule

/* design/ps2_timers.sv */
//----------------------------------------------------------
// Timers for the PS/2 host interface. A prescaler ticks the
// inhibit counter, which sets the clock inhibit time on
// transmit and acts as the idle watchdog on receive. A
// separate counter debounces the transmit clock edges
//----------------------------------------------------------

`timescale 1ns/10ps

module ps2_timers #(
  parameter int unsigned inhibit_ticks_p = 2950,
  parameter int unsigned prescale_div_p  = 186
) (
  input  logic clk,
  input  logic reset,
  input  logic inhibit_en_i,
  input  logic debounce_en_i,
  output logic inhibit_done_o,
  output logic debounce_done_o
);

  import ps2_ctrl_pkg::*;

  localparam logic [timer_width_c-1:0] prescale_last_c = timer_width_c'(prescale_div_p - 1);
  localparam logic [timer_width_c-1:0] inhibit_last_c  = timer_width_c'(inhibit_ticks_p);

  logic [timer_width_c-1:0] prescale_cnt;
  logic [timer_width_c-1:0] inhibit_cnt;
  logic [timer_width_c-1:0] debounce_cnt;
  logic                     prescale_tick;

  // tick once every prescale_div_p cycles of enable
  assign prescale_tick = (prescale_cnt == prescale_last_c);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      prescale_cnt <= '0;
      inhibit_cnt  <= '0;
      debounce_cnt <= '0;
    end
    else
    begin
      // prescaler and inhibit counter restart whenever the enable drops
      if (!inhibit_en_i || prescale_tick)
        prescale_cnt <= '0;
      else
        prescale_cnt <= prescale_cnt + 1'b1;
      if (!inhibit_en_i)
        inhibit_cnt <= '0;
      else if (prescale_tick && !inhibit_done_o)
        inhibit_cnt <= inhibit_cnt + 1'b1;
      // debounce counts clk cycles and holds at done
      if (!debounce_en_i)
        debounce_cnt <= '0;
      else if (!debounce_done_o)
        debounce_cnt <= debounce_cnt + 1'b1;
    end
  end

  assign inhibit_done_o  = (inhibit_cnt == inhibit_last_c);
  assign debounce_done_o = (debounce_cnt == prescale_last_c);

endmodule

/* design/ps2_line_ctrl.sv */
//----------------------------------------------------------
// Line control for the PS/2 host interface. Synchronizes the
// clock and data lines and runs the FSM that follows the
// device clock in receive and sequences a host command in
// transmit. The state is exported so the datapath blocks can
// act on the one-cycle edge marker states
//----------------------------------------------------------

`timescale 1ns/10ps

module ps2_line_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ps2_clk_i,
  input  logic                      ps2_data_i,
  input  logic                      tx_write_i,
  input  logic                      tx_bit_i,
  input  logic                      tx_shift_done_i,
  input  logic                      inhibit_done_i,
  input  logic                      debounce_done_i,
  output ps2_ctrl_pkg::line_state_t line_state_o,
  output logic                      ps2_data_sync_o,
  output logic                      ps2_clk_sync_o,
  output logic                      inhibit_en_o,
  output logic                      debounce_en_o,
  output logic                      ps2_clk_drive_low_o,
  output logic                      ps2_data_drive_low_o,
  output logic                      tx_write_ack_o,
  output logic                      tx_error_no_ack_o
);

  import ps2_ctrl_pkg::*;

  logic        clk_meta;
  logic        clk_sync;
  logic        data_meta;
  logic        data_sync;
  line_state_t state;
  line_state_t state_next;

  //----------------------------------------------------------
  // input synchronizers
  //----------------------------------------------------------

  // both lines idle high through the pullups, so the flops come
  // out of reset high and the FSM does not see a false edge
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      clk_meta  <= 1'b1;
      clk_sync  <= 1'b1;
      data_meta <= 1'b1;
      data_sync <= 1'b1;
    end
    else
    begin
      clk_meta  <= ps2_clk_i;
      clk_sync  <= clk_meta;
      data_meta <= ps2_data_i;
      data_sync <= data_meta;
    end
  end

  assign ps2_clk_sync_o  = clk_sync;
  assign ps2_data_sync_o = data_sync;

  //----------------------------------------------------------
  // line FSM
  //----------------------------------------------------------

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= rx_clk_high;
    end
    else
    begin
      state <= state_next;
    end
  end

  always_comb
  begin
    // lines are released and timers held clear unless a state says otherwise
    state_next           = state;
    ps2_clk_drive_low_o  = 1'b0;
    ps2_data_drive_low_o = 1'b0;
    inhibit_en_o         = 1'b0;
    debounce_en_o        = 1'b0;
    case (state)
      rx_clk_high:
      begin
        // the inhibit timer runs as the receive watchdog here
        inhibit_en_o = 1'b1;
        if (tx_write_i)
          state_next = tx_reset_timer;
        else if (!clk_sync)
          state_next = rx_fall_mark;
      end
      rx_clk_low:
      begin
        inhibit_en_o = 1'b1;
        if (tx_write_i)
          state_next = tx_reset_timer;
        else if (clk_sync)
          state_next = rx_rise_mark;
      end
      // one cycle markers, the shifter samples data on the fall mark
      rx_fall_mark: state_next = rx_clk_low;
      rx_rise_mark: state_next = rx_clk_high;
      // a cycle with the timer disabled restarts the inhibit count
      tx_reset_timer: state_next = tx_force_clk_low;
      tx_force_clk_low:
      begin
        inhibit_en_o        = 1'b1;
        ps2_clk_drive_low_o = 1'b1;
        if (inhibit_done_i)
          state_next = tx_first_wait_clk_high;
      end
      tx_first_wait_clk_high:
      begin
        // clock released, start bit held low until the device clocks
        debounce_en_o        = 1'b1;
        ps2_data_drive_low_o = 1'b1;
        if (!clk_sync && debounce_done_i)
          state_next = tx_clk_low;
      end
      tx_wait_clk_high:
      begin
        // the rising edge only counts once it has been stable
        debounce_en_o        = 1'b1;
        ps2_data_drive_low_o = !tx_bit_i;
        if (clk_sync && debounce_done_i)
          state_next = tx_rise_mark;
      end
      tx_rise_mark:
      begin
        ps2_data_drive_low_o = !tx_bit_i;
        state_next           = tx_clk_high;
      end
      tx_clk_high:
      begin
        ps2_data_drive_low_o = !tx_bit_i;
        if (tx_shift_done_i)
          state_next = tx_wait_ack;
        else if (!clk_sync)
          state_next = tx_clk_low;
      end
      tx_clk_low:
      begin
        ps2_data_drive_low_o = !tx_bit_i;
        if (clk_sync)
          state_next = tx_wait_clk_high;
      end
      tx_wait_ack:
      begin
        // device must pull data low while it drives the ack clock low
        if (!clk_sync && data_sync)
          state_next = tx_no_ack_error;
        else if (!clk_sync && !data_sync)
          state_next = tx_done_recovery;
      end
      tx_done_recovery, tx_no_ack_error:
      begin
        if (clk_sync && data_sync)
          state_next = rx_clk_high;
      end
      default: state_next = rx_clk_high;
    endcase
  end

  assign line_state_o = state;

  // a command is only accepted while the FSM is in a receive idle state
  assign tx_write_ack_o = tx_write_i && ((state == rx_clk_high) || (state == rx_clk_low));

  assign tx_error_no_ack_o = (state == tx_no_ack_error);

endmodule

/* design/ps2_ctrl_pkg.sv */
//----------------------------------------------------------
// Control definitions for the PS/2 host interface. The line
// state encoding is shared by the line FSM and the datapath
// blocks that decode its edge markers; the timer width sizes
// the prescaler, inhibit and debounce counters
//----------------------------------------------------------

package ps2_ctrl_pkg;

  // states of the line FSM, receive states first
  typedef enum logic [3:0] {
    rx_clk_high,
    rx_clk_low,
    rx_fall_mark,
    rx_rise_mark,
    tx_reset_timer,
    tx_force_clk_low,
    tx_first_wait_clk_high,
    tx_wait_clk_high,
    tx_rise_mark,
    tx_clk_high,
    tx_clk_low,
    tx_wait_ack,
    tx_done_recovery,
    tx_no_ack_error
  } line_state_t;

  // width of every timer counter in the design
  localparam int timer_width_c = 16;

endpackage

/* design/ps2_frame_pkg.sv */
//----------------------------------------------------------
// PS/2 frame layout shared by the shift register and the
// receive output logic. Holds the frame and bit counter sizes,
// the byte type used on the scan code and command ports, and
// the release prefix that translation absorbs
//----------------------------------------------------------

package ps2_frame_pkg;

  // one frame is start, eight data bits LSB first, parity and stop
  localparam int frame_bits_c = 11;

  // transmit shifting ends once start, data and parity have gone out
  localparam int tx_last_bit_c = 10;

  // scan code from the keyboard or command byte to the keyboard
  typedef logic [7:0] scan_code_t;

  // prefix sent by the keyboard ahead of a key release code
  localparam scan_code_t release_code_c = 8'hF0;

  // bit counter, one more value than a full frame is never needed
  typedef logic [3:0] bit_count_t;

endpackage
